// ==== vlog.f ====
verilog/udp_tx_pkg.sv
verilog/pkt_stream_if.sv
verilog/prot_eng_tx.sv
verilog/pkt_arbiter.sv
verilog/udp_tx_top.sv
tb/tb_udp_tx.sv

// ==== Makefile ====
# Verilator flow for the UDP/IP transmit framer
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_udp_tx
RTL_TOP   ?= udp_tx_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o $(TB_TOP)

# Result comes from the log, not the exit code of the run
sim: build
	./$(OBJ_DIR)/$(TB_TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_udp_tx.sv ====
// Testbench for the two-channel UDP/IP transmit framer
// Directed tests against a reference header model, random output stalls
`timescale 1ns/1ps
`default_nettype none

module tb_udp_tx
   import udp_tx_pkg::*;
();

   localparam int          CLK_PERIOD = 40;
   localparam int          SAMPLE_DLY = CLK_PERIOD/2 - 2;   // Just before rising edge
   localparam int          TIMEOUT    = 300;                // Cycles per wait
   localparam logic [31:0] SEED       = 32'he119_491d;

   // Header line flags in bits 20:16 of a RAM entry
   localparam logic [4:0] F_PORT   = 5'b10000;
   localparam logic [4:0] F_LAST   = 5'b01000;
   localparam logic [4:0] F_CHK    = 5'b00100;
   localparam logic [4:0] F_IPLEN  = 5'b00010;
   localparam logic [4:0] F_UDPLEN = 5'b00001;

   typedef logic [18:0] beat_t;    // sof, eof, occ, data

   logic      clk;
   logic      reset;
   logic      set_stb_i;
   set_addr_t set_addr_i;
   set_data_t set_data_i;
   data16_t   in0_data_i;
   logic      in0_sof_i;
   logic      in0_eof_i;
   logic      in0_occ_i;
   logic      in0_src_rdy_i;
   logic      in0_dst_rdy_o;
   data16_t   in1_data_i;
   logic      in1_sof_i;
   logic      in1_eof_i;
   logic      in1_occ_i;
   logic      in1_src_rdy_i;
   logic      in1_dst_rdy_o;
   data16_t   out_data_o;
   logic      out_sof_o;
   logic      out_eof_o;
   logic      out_occ_o;
   logic      out_src_rdy_o;
   logic      out_dst_rdy_i;

   hdr_word_t   hdr_model [2][HDR_LEN];   // Mirror of each header RAM
   data16_t     port_model [2][4];
   data16_t     pre_model [2];            // Checksum precompute per engine
   beat_t       tx0_q[$];
   beat_t       tx1_q[$];
   beat_t       exp_q[$];                 // Expected output words
   beat_t       mon_q[$];                 // Observed output words
   int          mon_base = 0;
   logic [31:0] data_seed  = SEED;
   logic [31:0] stall_seed = SEED;
   logic        stall_en   = 1'b0;
   int          errors     = 0;
   int          timeouts   = 0;

   udp_tx_top dut_i (.*);

   initial
   begin
      clk = 1'b0;
      forever
         #(CLK_PERIOD/2) clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(inout logic [31:0] state);
      state = state * 32'd1664525 + 32'd1013904223;
      return state;
   endfunction

   // Inverted one's-complement sum of precompute and IP length
   function automatic data16_t ip_checksum(input data16_t pre, input data16_t ip_len);
      logic [31:0] sum;
      sum = {16'h0, pre} + {16'h0, ip_len};
      sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};   // Fold carry back in
      sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
      return ~sum[15:0];
   endfunction

   task automatic check_word(input string name, input data16_t exp, input data16_t act);
      if (act !== exp)
      begin
         errors++;
         $display("ERROR %s: data expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_flags(input string name, input logic [2:0] exp, input logic [2:0] act);
      if (act !== exp)
      begin
         errors++;
         $display("ERROR %s: sof/eof/occ expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp)
      begin
         errors++;
         $display("ERROR %s: word count expected %0d actual %0d", name, exp, act);
      end
   endtask

   // One strobe on the settings bus
   task automatic write_setting(input int addr, input set_data_t data);
      @(negedge clk);
      set_stb_i  = 1'b1;
      set_addr_i = set_addr_t'(addr);
      set_data_i = data;
      @(negedge clk);
      set_stb_i  = 1'b0;
   endtask

   task automatic program_line(input int eng, input int idx, input logic [4:0] flags,
                               input data16_t data);
      hdr_word_t w;
      w = {flags, data};
      write_setting((eng == 0 ? ENG0_BASE : ENG1_BASE) + idx, {11'h0, w});
      hdr_model[eng][idx] = w;
      if (flags[2])
         pre_model[eng] = data;                 // Checksum line carries precompute
      if (idx >= 24 && idx < 28)
         port_model[eng][idx-24] = data;
   endtask

   // Literals with the two lengths only
   task automatic load_basic_header(input int eng);
      program_line(eng, 2, 5'b0, 16'h4500);
      program_line(eng, 3, F_IPLEN, '0);
      program_line(eng, 4, 5'b0, 16'h1c46);
      program_line(eng, 5, F_UDPLEN, '0);
      program_line(eng, 6, F_LAST, 16'h0000);
   endtask

   // Full IPv4 plus UDP header where tag makes each engine's header distinct
   task automatic load_udp_header(input int eng, input data16_t tag, input data16_t pre);
      program_line(eng, 2, 5'b0, 16'h4500);
      program_line(eng, 3, F_IPLEN, '0);
      program_line(eng, 4, 5'b0, tag);          // Identification
      program_line(eng, 5, 5'b0, 16'h4000);     // Don't fragment
      program_line(eng, 6, 5'b0, 16'h4011);     // TTL and protocol UDP
      program_line(eng, 7, F_CHK, pre);
      program_line(eng, 8, 5'b0, 16'hc0a8);
      program_line(eng, 9, 5'b0, tag ^ 16'h0101);
      program_line(eng, 10, 5'b0, 16'hc0a8);
      program_line(eng, 11, 5'b0, 16'h0a01);
      program_line(eng, 12, F_PORT, '0);        // Source port from table
      program_line(eng, 13, 5'b0, 16'h1388);
      program_line(eng, 14, F_UDPLEN, '0);
      program_line(eng, 15, F_LAST, 16'h0000);  // UDP checksum unused
      for (int p = 0; p < 4; p++)
         program_line(eng, 24 + p, 5'b0, tag + 16'h0111 * data16_t'(p));
   endtask

   task automatic queue_tx(input int ch, input beat_t b);
      if (ch == 0)
         tx0_q.push_back(b);
      else
         tx1_q.push_back(b);
   endtask

   function automatic beat_t take_tx(input int ch);
      return (ch == 0) ? tx0_q.pop_front() : tx1_q.pop_front();
   endfunction

   function automatic int tx_pending(input int ch);
      return (ch == 0) ? tx0_q.size() : tx1_q.size();
   endfunction

   task automatic flush_tx(input int ch);
      if (ch == 0)
         tx0_q.delete();
      else
         tx1_q.delete();
   endtask

   task automatic set_channel(input int ch, input beat_t b, input logic vld);
      if (ch == 0)
      begin
         {in0_sof_i, in0_eof_i, in0_occ_i, in0_data_i} = b;
         in0_src_rdy_i = vld;
      end
      else
      begin
         {in1_sof_i, in1_eof_i, in1_occ_i, in1_data_i} = b;
         in1_src_rdy_i = vld;
      end
   endtask

   function automatic logic channel_ready(input int ch);
      return (ch == 0) ? in0_dst_rdy_o : in1_dst_rdy_o;
   endfunction

   // Queue one input packet and its expected output words
   task automatic build_packet(input int eng, input logic fast, input int port,
                               input int nbytes);
      data16_t     len;
      data16_t     ctrl;
      data16_t     word;
      hdr_word_t   line;
      logic [31:0] r;
      logic        first;
      logic        last;
      logic        odd;
      int          nwords;
      int          idx;
      len    = data16_t'(nbytes);
      ctrl   = {13'h0, 2'(port), fast};
      nwords = (nbytes + 1) / 2;
      first  = 1'b1;
      queue_tx(eng, {3'b100, ctrl});
      queue_tx(eng, {3'b000, len});
      if (fast)
      begin
         idx = 2;                          // First header line
         do
         begin
            line = hdr_model[eng][idx];
            if (line[20])
               word = port_model[eng][port];
            else if (line[18])
               word = ip_checksum(pre_model[eng], len + IP_UDP_HDR_BYTES);
            else if (line[17])
               word = len + IP_UDP_HDR_BYTES;
            else if (line[16])
               word = len + UDP_HDR_BYTES;
            else
               word = line[15:0];
            exp_q.push_back({first, 2'b00, word});
            first = 1'b0;
            idx++;
         end
         while (!line[19] && idx < 24);
      end
      else
      begin
         r = lcg_next(data_seed);
         queue_tx(eng, {3'b000, r[31:16]});   // Alignment word, dropped
      end
      for (int i = 0; i < nwords; i++)
      begin
         r    = lcg_next(data_seed);
         last = (i == nwords - 1);
         odd  = last && (nbytes % 2 == 1);
         queue_tx(eng, {1'b0, last, odd, r[31:16]});
         exp_q.push_back({first, last, odd, r[31:16]});
         first = 1'b0;
      end
   endtask

   // Offer each queued word until the engine takes it
   task automatic drive_channel(input int ch);
      beat_t w;
      int    waited;
      logic  taken;
      @(negedge clk);
      while (tx_pending(ch) > 0)
      begin
         w      = take_tx(ch);
         set_channel(ch, w, 1'b1);
         waited = 0;
         taken  = 1'b0;
         while (!taken && waited < TIMEOUT)
         begin
            #(SAMPLE_DLY);
            taken = channel_ready(ch);     // src_rdy is high here
            waited++;
            @(negedge clk);
         end
         if (!taken)
         begin
            timeouts++;
            $display("Timeout: channel %0d never accepted input word %h", ch, w[15:0]);
            flush_tx(ch);
         end
      end
      set_channel(ch, '0, 1'b0);
   endtask

   task automatic send_and_compare(input string name);
      int waited;
      int got;
      fork
         drive_channel(0);
         drive_channel(1);
      join
      waited = 0;
      while (mon_q.size() - mon_base < exp_q.size() && waited < TIMEOUT)
      begin
         @(negedge clk);
         waited++;
      end
      if (mon_q.size() - mon_base < exp_q.size())
      begin
         timeouts++;
         $display("Timeout: %s output stopped before all expected words arrived", name);
      end
      repeat (4) @(negedge clk);           // Room for stray extra words
      got = mon_q.size() - mon_base;
      check_count(name, exp_q.size(), got);
      for (int i = 0; i < exp_q.size() && i < got; i++)
      begin
         check_flags(name, exp_q[i][18:16], mon_q[mon_base+i][18:16]);
         check_word(name, exp_q[i][15:0], mon_q[mon_base+i][15:0]);
      end
      exp_q.delete();
      mon_base = mon_q.size();
   endtask

   task automatic fast_path_framing();
      load_basic_header(0);
      stall_en = 1'b0;
      build_packet(0, 1'b1, 0, 9);
      send_and_compare("fast_path");
      stall_en = 1'b1;                     // Stalls from here on
      build_packet(0, 1'b1, 0, 14);
      build_packet(0, 1'b1, 0, 1);         // Single odd byte
      send_and_compare("fast_path_stall");
   endtask

   // Precompute near the top so some lengths carry around and some do not
   task automatic checksum_and_ports();
      load_udp_header(0, 16'h1a2b, 16'hffd8);
      for (int p = 0; p < 4; p++)
         build_packet(0, 1'b1, p, 5 + 7 * p);
      send_and_compare("checksum_port");
   endtask

   task automatic slow_path_passthrough();
      build_packet(0, 1'b0, 0, 7);
      build_packet(0, 1'b0, 2, 2);         // One word, sof and eof together
      send_and_compare("slow_path");
   endtask

   // Same packet through each engine gives that engine's header
   task automatic engine1_window();
      logic [31:0] saved;
      load_udp_header(1, 16'h5e71, 16'h7c3a);
      saved = data_seed;
      build_packet(0, 1'b1, 2, 12);
      send_and_compare("eng0_window");
      data_seed = saved;
      build_packet(1, 1'b1, 2, 12);
      send_and_compare("eng1_window");
   endtask

   // Engine 1 went last so engine 0 wins first and then strict alternation
   task automatic arbitration_order();
      build_packet(0, 1'b1, 1, 10);
      build_packet(1, 1'b1, 3, 6);
      build_packet(0, 1'b1, 0, 3);
      build_packet(1, 1'b0, 0, 8);
      send_and_compare("arbitration");
   endtask

   // Output stall pattern of about one cycle in four
   initial
   begin : stall_gen
      logic [31:0] r;
      out_dst_rdy_i = 1'b1;
      forever
      begin
         @(negedge clk);
         r = lcg_next(stall_seed);
         out_dst_rdy_i = !stall_en || (r[31:30] != 2'b00);
      end
   end

   // Output monitor sampling just before each rising edge
   initial
   begin
      forever
      begin
         @(negedge clk);
         #(SAMPLE_DLY);
         if (!reset && out_src_rdy_o && out_dst_rdy_i)
            mon_q.push_back({out_sof_o, out_eof_o, out_occ_o, out_data_o});
      end
   end

   initial
   begin
      reset      = 1'b1;
      set_stb_i  = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      set_channel(0, '0, 1'b0);
      set_channel(1, '0, 1'b0);
      repeat (3) @(negedge clk);
      reset = 1'b0;
      fast_path_framing();
      checksum_and_ports();
      slow_path_passthrough();
      engine1_window();
      arbitration_order();
      $display("Mismatches: %0d  Timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/udp_tx_top.sv ====
// Two-channel UDP/IP transmit framer
// Two protocol engines share one output stream through a packet arbiter
`timescale 1ns/1ps
`default_nettype none

module udp_tx_top
   import udp_tx_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   // Settings bus
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   // Channel 0 input
   input  data16_t   in0_data_i,
   input  logic      in0_sof_i,
   input  logic      in0_eof_i,
   input  logic      in0_occ_i,
   input  logic      in0_src_rdy_i,
   output logic      in0_dst_rdy_o,
   // Channel 1 input
   input  data16_t   in1_data_i,
   input  logic      in1_sof_i,
   input  logic      in1_eof_i,
   input  logic      in1_occ_i,
   input  logic      in1_src_rdy_i,
   output logic      in1_dst_rdy_o,
   // Shared output
   output data16_t   out_data_o,
   output logic      out_sof_o,
   output logic      out_eof_o,
   output logic      out_occ_o,
   output logic      out_src_rdy_o,
   input  logic      out_dst_rdy_i
);

   pkt_stream_if in0_s ();
   pkt_stream_if in1_s ();
   pkt_stream_if eng_s [NUM_ENG] ();    // Engine to arbiter
   pkt_stream_if out_s ();

   assign in0_s.data    = in0_data_i;
   assign in0_s.sof     = in0_sof_i;
   assign in0_s.eof     = in0_eof_i;
   assign in0_s.occ     = in0_occ_i;
   assign in0_s.src_rdy = in0_src_rdy_i;
   assign in0_dst_rdy_o = in0_s.dst_rdy;

   assign in1_s.data    = in1_data_i;
   assign in1_s.sof     = in1_sof_i;
   assign in1_s.eof     = in1_eof_i;
   assign in1_s.occ     = in1_occ_i;
   assign in1_s.src_rdy = in1_src_rdy_i;
   assign in1_dst_rdy_o = in1_s.dst_rdy;

   prot_eng_tx #(.BASE(ENG0_BASE)) eng0_i
   (
      .clk        (clk),
      .reset      (reset),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .in_s       (in0_s),
      .out_s      (eng_s[0])
   );

   prot_eng_tx #(.BASE(ENG1_BASE)) eng1_i
   (
      .clk        (clk),
      .reset      (reset),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .in_s       (in1_s),
      .out_s      (eng_s[1])
   );

   pkt_arbiter arb_i
   (
      .clk   (clk),
      .reset (reset),
      .req_s (eng_s),
      .out_s (out_s)
   );

   assign out_data_o    = out_s.data;
   assign out_sof_o     = out_s.sof;
   assign out_eof_o     = out_s.eof;
   assign out_occ_o     = out_s.occ;
   assign out_src_rdy_o = out_s.src_rdy;
   assign out_s.dst_rdy = out_dst_rdy_i;

endmodule

`default_nettype wire

// ==== verilog/pkt_arbiter.sv ====
// Round-robin packet arbiter
// Locks the granted engine onto the output from sof to eof
`timescale 1ns/1ps
`default_nettype none

module pkt_arbiter
   import udp_tx_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   pkt_stream_if.dst req_s [NUM_ENG],
   pkt_stream_if.src out_s
);

   data16_t            req_data [NUM_ENG];
   logic [NUM_ENG-1:0] req_sof;
   logic [NUM_ENG-1:0] req_eof;
   logic [NUM_ENG-1:0] req_occ;
   logic [NUM_ENG-1:0] req_vld;
   logic               lock;     // Packet in flight
   eng_idx_t           grant;    // Owner or last served when idle
   eng_idx_t           pick;
   eng_idx_t           cur;
   logic               out_xfer;

   // Flatten the interface array for indexed access
   for (genvar i = 0; i < NUM_ENG; i++)
   begin : g_req
      assign req_data[i]     = req_s[i].data;
      assign req_sof[i]      = req_s[i].sof;
      assign req_eof[i]      = req_s[i].eof;
      assign req_occ[i]      = req_s[i].occ;
      assign req_vld[i]      = req_s[i].src_rdy;
      assign req_s[i].dst_rdy = out_s.dst_rdy & (cur == eng_idx_t'(i));  // Granted only
   end

   // Next requester after the last served one wins
   always_comb
   begin : p_pick
      eng_idx_t idx;
      pick = grant;
      for (int k = NUM_ENG; k >= 1; k--)
      begin
         idx = eng_idx_t'((int'(grant) + k) % NUM_ENG);
         if (req_vld[idx])
            pick = idx;
      end
   end

   assign cur = lock ? grant : pick;

   assign out_s.data    = req_data[cur];
   assign out_s.sof     = req_sof[cur];
   assign out_s.eof     = req_eof[cur];
   assign out_s.occ     = req_occ[cur];
   assign out_s.src_rdy = req_vld[cur];
   assign out_xfer      = out_s.src_rdy & out_s.dst_rdy;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         lock  <= 1'b0;
         grant <= '0;
      end
      else if (out_xfer)
      begin
         grant <= cur;
         lock  <= ~out_s.eof;    // Release after eof even on single word packets
      end
   end

   // A fresh grant always starts on a sof word
   a_start_sof: assert property (@(posedge clk) disable iff (reset)
      (out_xfer && !lock) |-> out_s.sof);

   // Engines raise sof only at packet start and never mid-lock
   a_sof_unlocked: assert property (@(posedge clk) disable iff (reset)
      (out_s.src_rdy && out_s.sof) |-> !lock);

endmodule

`default_nettype wire

// ==== verilog/prot_eng_tx.sv ====
// UDP/IP transmit protocol engine
// Fast path prepends a header from RAM with lengths, checksum and port patched in
// Slow path drops the alignment word and passes the payload through
`timescale 1ns/1ps
`default_nettype none

module prot_eng_tx
   import udp_tx_pkg::*;
#(
   parameter int BASE = 0              // Settings window base
)
(
   input  logic      clk,
   input  logic      reset,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   pkt_stream_if.dst in_s,
   pkt_stream_if.src out_s
);

   hdr_word_t  hdr_ram [HDR_LEN];      // Programmable header lines
   data16_t    port_tbl [4];           // Per-port UDP port words
   data16_t    chk_precompute;         // Partial header checksum
   eng_state_t state;
   hdr_idx_t   hdr_idx;
   logic       sof_r;
   logic       fast_path;
   logic [1:0] port_sel;
   data16_t    length_r;               // Payload bytes
   data16_t    checksum_reg;
   hdr_word_t  hdr_line;
   data16_t    udp_port;
   data16_t    ip_len;
   data16_t    udp_len;
   data16_t    len_ip_in;
   data16_t    hdr_data;
   logic       win_hit;
   logic       in_xfer;
   logic       out_xfer;

   // End-around carry add
   function automatic data16_t ones_add(input data16_t a, input data16_t b);
      logic [DATA_W:0] sum;
      sum = {1'b0, a} + {1'b0, b};
      return sum[DATA_W-1:0] + {{(DATA_W-1){1'b0}}, sum[DATA_W]};
   endfunction

   assign in_xfer  = in_s.src_rdy & in_s.dst_rdy;
   assign out_xfer = out_s.src_rdy & out_s.dst_rdy;
   assign win_hit  = set_stb_i && (set_addr_i[7:5] == BASE[7:5]);

   // Settings writes
   always_ff @(posedge clk)
   begin
      if (win_hit)
      begin
         hdr_ram[set_addr_i[4:0]] <= set_data_i[HDR_W-1:0];
         if (set_data_i[HB_CHK])
            chk_precompute <= set_data_i[DATA_W-1:0];  // Checksum line carries precompute
      end
      if (win_hit && set_addr_i[4:2] == PORT_OFFSET[4:2])
         port_tbl[set_addr_i[1:0]] <= set_data_i[DATA_W-1:0];
   end

   assign hdr_line  = hdr_ram[hdr_idx];
   assign udp_port  = port_tbl[port_sel];
   assign ip_len    = length_r + IP_UDP_HDR_BYTES;
   assign udp_len   = length_r + UDP_HDR_BYTES;
   assign len_ip_in = in_s.data + IP_UDP_HDR_BYTES;  // IP length of word now on input

   // Packet control and length capture
   always_ff @(posedge clk)
   begin
      if (in_xfer && state == ST_CTRL)
      begin
         fast_path <= in_s.data[0];
         port_sel  <= in_s.data[2:1];
      end
      if (in_xfer && state == ST_LEN)
      begin
         length_r     <= in_s.data;
         checksum_reg <= ~ones_add(chk_precompute, len_ip_in);  // Ready before first line
      end
   end

   // Framing FSM
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= ST_CTRL;
         sof_r   <= 1'b0;
         hdr_idx <= HDR_FIRST;
      end
      else
      begin
         if (out_xfer)
            sof_r <= 1'b0;               // Only on first emitted word
         case (state)
            ST_CTRL:
               if (in_xfer)
                  state <= ST_LEN;
            ST_LEN:
               if (in_xfer)
               begin
                  sof_r   <= 1'b1;
                  hdr_idx <= HDR_FIRST;
                  state   <= fast_path ? ST_HDR : ST_ALIGN;
               end
            ST_ALIGN:
               if (in_xfer)
                  state <= ST_PAYLOAD;   // Alignment word dropped
            ST_HDR:
               if (out_xfer)
               begin
                  if (hdr_line[HB_LAST])
                     state <= ST_PAYLOAD;
                  else
                     hdr_idx <= hdr_idx + 1'b1;
               end
            ST_PAYLOAD:
               if (out_xfer && in_s.eof)
                  state <= ST_CTRL;
            default:
               state <= ST_CTRL;
         endcase
      end
   end

   // Header field substitution
   always_comb
   begin
      if (hdr_line[HB_CHK])
         hdr_data = checksum_reg;
      else if (hdr_line[HB_IPLEN])
         hdr_data = ip_len;
      else if (hdr_line[HB_UDPLEN])
         hdr_data = udp_len;
      else if (hdr_line[HB_PORT])
         hdr_data = udp_port;
      else
         hdr_data = hdr_line[DATA_W-1:0];    // Literal
   end

   assign out_s.sof = sof_r;

   // Stream steering with zero latency in header and payload
   always_comb
   begin
      out_s.data    = in_s.data;
      out_s.eof     = 1'b0;
      out_s.occ     = 1'b0;
      out_s.src_rdy = 1'b0;
      in_s.dst_rdy  = 1'b1;              // Control, length, alignment consumed freely
      case (state)
         ST_HDR:
         begin
            out_s.data    = hdr_data;
            out_s.src_rdy = in_s.src_rdy;   // First payload word must be waiting
            in_s.dst_rdy  = 1'b0;
         end
         ST_PAYLOAD:
         begin
            out_s.eof     = in_s.eof;
            out_s.occ     = in_s.occ;
            out_s.src_rdy = in_s.src_rdy;
            in_s.dst_rdy  = out_s.dst_rdy;
         end
         default:
         begin
         end
      endcase
   end

   // Header walk must meet a last line before the port words
   a_hdr_bound: assert property (@(posedge clk) disable iff (reset)
      (state == ST_HDR) |-> (hdr_idx < PORT_OFFSET));

   // No second sof once payload words flow
   a_sof_once: assert property (@(posedge clk) disable iff (reset)
      (state == ST_PAYLOAD && out_xfer) |=> !out_s.sof);

endmodule

`default_nettype wire

// ==== verilog/pkt_stream_if.sv ====
// 16-bit packet stream with frame flags
// Word moves when src_rdy and dst_rdy are both high
`timescale 1ns/1ps
`default_nettype none

interface pkt_stream_if
   import udp_tx_pkg::*;
();

   data16_t data;
   logic    sof;      // Start of frame
   logic    eof;      // End of frame
   logic    occ;      // Odd byte count, last word half full
   logic    src_rdy;
   logic    dst_rdy;

   // Source side drives data and flags
   modport src
   (
      output data, sof, eof, occ, src_rdy,
      input  dst_rdy
   );

   // Sink side only drives the ready
   modport dst
   (
      input  data, sof, eof, occ, src_rdy,
      output dst_rdy
   );

endinterface

`default_nettype wire

// ==== verilog/udp_tx_pkg.sv ====
// UDP/IP transmit framer shared definitions
// Widths, settings address map, header line flags and engine states
`default_nettype none

package udp_tx_pkg;

   localparam int DATA_W     = 16;
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   localparam int HDR_W      = 21;    // Flags plus literal word
   localparam int HDR_IDX_W  = 5;
   localparam int NUM_ENG    = 2;     // Protocol engines sharing the output
   localparam int ENG_IDX_W  = $clog2(NUM_ENG);

   typedef logic [DATA_W-1:0]     data16_t;    // Stream word, header word or length
   typedef logic [SET_ADDR_W-1:0] set_addr_t;
   typedef logic [SET_DATA_W-1:0] set_data_t;
   typedef logic [HDR_W-1:0]      hdr_word_t;  // Header RAM entry
   typedef logic [HDR_IDX_W-1:0]  hdr_idx_t;
   typedef logic [ENG_IDX_W-1:0]  eng_idx_t;   // Arbiter grant index

   // Header line flag positions
   localparam int HB_PORT   = 20;     // UDP port word here
   localparam int HB_LAST   = 19;     // Last header line
   localparam int HB_CHK    = 18;     // IP header checksum here
   localparam int HB_IPLEN  = 17;     // IP total length here
   localparam int HB_UDPLEN = 16;     // UDP length here

   localparam int       HDR_LEN     = 32;      // RAM depth
   localparam hdr_idx_t HDR_FIRST   = 5'd2;    // First header line used
   localparam hdr_idx_t PORT_OFFSET = 5'd24;   // Port words at BASE+24..27

   localparam data16_t IP_UDP_HDR_BYTES = 16'd28;
   localparam data16_t UDP_HDR_BYTES    = 16'd8;

   // Settings windows, 32 addresses each
   localparam int ENG0_BASE = 0;
   localparam int ENG1_BASE = 32;

   typedef enum logic [2:0] {
      ST_CTRL,       // Control word
      ST_LEN,        // Length word
      ST_HDR,        // Emitting header lines
      ST_ALIGN,      // Slow path alignment word
      ST_PAYLOAD
   } eng_state_t;

endpackage

`default_nettype wire
